// File: design/xif_offload_pkg.sv
/*
  Offload subsystem package: data widths, the narrow core-side and
  wide coprocessor-side channel structs, the custom-0 opcode and FSM states
*/
package xif_offload_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  xif_id_t;
  typedef logic [31:0] instr_t;

  // Core side, older narrow interface
  typedef struct packed {
    xif_id_t id;
    instr_t  instr;
  } core_issue_req_t;

  typedef struct packed {
    xlen_t [1:0] rs;
    logic  [1:0] rs_valid;
  } core_register_t;

  typedef struct packed {
    logic       accept;
    logic       writeback;
    logic [1:0] register_read;
  } core_issue_resp_t;

  typedef struct packed {
    xif_id_t id;
    logic    commit_kill;
  } core_commit_t;

  typedef struct packed {
    xif_id_t   id;
    xlen_t     data;
    reg_addr_t rd;
    logic      we;
  } core_result_t;

  // Coprocessor side, newer wide interface
  typedef struct packed {
    logic [1:0]  mode;
    xif_id_t     id;
    instr_t      instr;
    xlen_t [2:0] rs;
    logic  [2:0] rs_valid;
    logic        ecs_valid;
  } cp_issue_req_t;

  typedef struct packed {
    logic       accept;
    logic       writeback;
    logic       dualwrite;
    logic [2:0] dualread;
    logic       loadstore;
    logic       exc;
  } cp_issue_resp_t;

  typedef struct packed {
    xif_id_t id;
    logic    commit_kill;
  } cp_commit_t;

  typedef struct packed {
    xif_id_t   id;
    xlen_t     data;
    reg_addr_t rd;
    logic      we;
    logic      hartid;
  } cp_result_t;

  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b000_1011;

  // funct3 encodings of the custom-0 operations
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_XOR  = 3'd2,
    OP_MINU = 3'd3,
    OP_ROL  = 3'd4
  } cp_op_e;

  typedef enum logic [1:0] {
    ISS_IDLE,
    ISS_ISSUE,
    ISS_COMMIT,
    ISS_WAIT_RESULT
  } issuer_state_e;

  typedef enum logic [1:0] {
    CP_IDLE,
    CP_WAIT_COMMIT,
    CP_RESULT
  } coproc_state_e;

endpackage

// File: design/offload_issuer.sv
/*
  Core-side issue unit. Holds the register file, issues one instruction
  at a time over the narrow extension interface, commits or kills it
  and writes the returned result back
*/
`timescale 1ns/100ps

module offload_issuer #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Instruction input
  input  logic                               offload_valid_i,
  input  xif_offload_pkg::instr_t            offload_instr_i,
  output logic                               offload_ready_o,
  // Register preload and readback
  input  logic                               reg_we_i,
  input  xif_offload_pkg::reg_addr_t         reg_waddr_i,
  input  xif_offload_pkg::xlen_t             reg_wdata_i,
  input  xif_offload_pkg::reg_addr_t         reg_raddr_i,
  output xif_offload_pkg::xlen_t             reg_rdata_o,
  // Completion pulses
  output logic                               done_o,
  output logic                               illegal_o,
  // Issue channel
  output logic                               x_issue_valid_o,
  input  logic                               x_issue_ready_i,
  output xif_offload_pkg::core_issue_req_t   x_issue_req_o,
  output xif_offload_pkg::core_register_t    x_register_o,
  input  xif_offload_pkg::core_issue_resp_t  x_issue_resp_i,
  // Commit channel
  output logic                               x_commit_valid_o,
  output xif_offload_pkg::core_commit_t      x_commit_o,
  // Result channel
  input  logic                               x_result_valid_i,
  output logic                               x_result_ready_o,
  input  xif_offload_pkg::core_result_t      x_result_i
);

  import xif_offload_pkg::*;

  issuer_state_e state_q, state_d;
  xif_id_t       id_q;
  instr_t        instr_q;
  logic          accepted_q;

  logic          offload_hs;
  logic          result_hs;

  logic          rf_we;
  reg_addr_t     rf_waddr;
  xlen_t         rf_wdata;
  xlen_t         rf_q [32];

  assign offload_ready_o = (state_q == ISS_IDLE);
  assign offload_hs      = offload_valid_i && offload_ready_o;
  assign result_hs       = x_result_valid_i && x_result_ready_o;

  assign done_o    = result_hs;
  assign illegal_o = (state_q == ISS_COMMIT) && !accepted_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ISS_IDLE: begin
        if (offload_hs) begin
          state_d = ISS_ISSUE;
        end
      end
      ISS_ISSUE: begin
        if (x_issue_ready_i) begin
          state_d = ISS_COMMIT;
        end
      end
      ISS_COMMIT: begin
        state_d = accepted_q ? ISS_WAIT_RESULT : ISS_IDLE;
      end
      ISS_WAIT_RESULT: begin
        if (result_hs) begin
          state_d = ISS_IDLE;
        end
      end
      default: state_d = ISS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ISS_IDLE;
      id_q       <= '0;
      accepted_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ISS_ISSUE && x_issue_ready_i) begin
        accepted_q <= x_issue_resp_i.accept;
      end
      // Next id once the current instruction has ended
      if (illegal_o || done_o) begin
        id_q <= id_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (offload_hs) begin
      instr_q <= offload_instr_i;
    end
  end

  // Outgoing channels
  assign x_issue_valid_o        = (state_q == ISS_ISSUE);
  assign x_issue_req_o.id       = id_q;
  assign x_issue_req_o.instr    = instr_q;
  assign x_register_o.rs[0]     = rf_q[instr_q[19:15]];
  assign x_register_o.rs[1]     = rf_q[instr_q[24:20]];
  assign x_register_o.rs_valid  = 2'b11;

  assign x_commit_valid_o       = (state_q == ISS_COMMIT);
  assign x_commit_o.id          = id_q;
  assign x_commit_o.commit_kill = !accepted_q;

  assign x_result_ready_o       = (state_q == ISS_WAIT_RESULT);

  // Result writeback, otherwise preload while idle
  always_comb begin
    if (state_q == ISS_WAIT_RESULT) begin
      rf_we    = result_hs && x_result_i.we && (x_result_i.rd != '0);
      rf_waddr = x_result_i.rd;
      rf_wdata = x_result_i.data;
    end else begin
      rf_we    = reg_we_i && (state_q == ISS_IDLE);
      rf_waddr = reg_waddr_i;
      rf_wdata = reg_wdata_i;
    end
  end

  // x0 and unimplemented indices are constant zero
  for (genvar i = 0; i < 32; i++) begin : g_rf
    if (i == 0 || i >= NumRegs) begin : g_zero
      assign rf_q[i] = '0;
    end else begin : g_reg
      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          rf_q[i] <= '0;
        end else if (rf_we && rf_waddr == reg_addr_t'(i)) begin
          rf_q[i] <= rf_wdata;
        end
      end
    end
  end

  assign reg_rdata_o = rf_q[reg_raddr_i];

endmodule

// File: design/xif_adapter.sv
/*
  Extension interface adapter. Translates the narrow core-side channels
  to the wide coprocessor-side ones and buffers one result
*/
`timescale 1ns/100ps

module xif_adapter (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Core side
  input  logic                               x_issue_valid_i,
  output logic                               x_issue_ready_o,
  input  xif_offload_pkg::core_issue_req_t   x_issue_req_i,
  input  xif_offload_pkg::core_register_t    x_register_i,
  output xif_offload_pkg::core_issue_resp_t  x_issue_resp_o,
  input  logic                               x_commit_valid_i,
  input  xif_offload_pkg::core_commit_t      x_commit_i,
  output logic                               x_result_valid_o,
  input  logic                               x_result_ready_i,
  output xif_offload_pkg::core_result_t      x_result_o,
  // Coprocessor side
  output logic                               cp_issue_valid_o,
  input  logic                               cp_issue_ready_i,
  output xif_offload_pkg::cp_issue_req_t     cp_issue_req_o,
  input  xif_offload_pkg::cp_issue_resp_t    cp_issue_resp_i,
  output logic                               cp_commit_valid_o,
  output xif_offload_pkg::cp_commit_t        cp_commit_o,
  input  logic                               cp_result_valid_i,
  output logic                               cp_result_ready_o,
  input  xif_offload_pkg::cp_result_t        cp_result_i
);

  import xif_offload_pkg::*;

  logic         slot_valid_q;
  core_result_t slot_q;

  // Issue request, third operand and extension state unused
  assign cp_issue_valid_o         = x_issue_valid_i;
  assign x_issue_ready_o          = cp_issue_ready_i;
  assign cp_issue_req_o.mode      = '0;
  assign cp_issue_req_o.id        = x_issue_req_i.id;
  assign cp_issue_req_o.instr     = x_issue_req_i.instr;
  assign cp_issue_req_o.rs[0]     = x_register_i.rs[0];
  assign cp_issue_req_o.rs[1]     = x_register_i.rs[1];
  assign cp_issue_req_o.rs[2]     = '0;
  assign cp_issue_req_o.rs_valid  = {1'b0, x_register_i.rs_valid};
  assign cp_issue_req_o.ecs_valid = 1'b0;

  // The core has nothing in flight, so it may as well read every operand
  assign x_issue_resp_o.accept        = cp_issue_resp_i.accept;
  assign x_issue_resp_o.writeback     = cp_issue_resp_i.writeback;
  assign x_issue_resp_o.register_read = 2'b11;

  assign cp_commit_valid_o       = x_commit_valid_i;
  assign cp_commit_o.id          = x_commit_i.id;
  assign cp_commit_o.commit_kill = x_commit_i.commit_kill;

  // One-entry result slice
  assign cp_result_ready_o = !slot_valid_q || x_result_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_valid_q <= 1'b0;
    end else if (cp_result_ready_o) begin
      slot_valid_q <= cp_result_valid_i;
    end
  end

  // hartid is dropped on the way in
  always_ff @(posedge clk_i) begin
    if (cp_result_valid_i && cp_result_ready_o) begin
      slot_q.id   <= cp_result_i.id;
      slot_q.data <= cp_result_i.data;
      slot_q.rd   <= cp_result_i.rd;
      slot_q.we   <= cp_result_i.we;
    end
  end

  assign x_result_valid_o = slot_valid_q;
  assign x_result_o       = slot_q;

endmodule

// File: design/xif_coproc.sv
/*
  Custom-0 coprocessor. Decodes and accepts R-type instructions, waits
  for the commit and returns add, sub, xor, minu or rol results
*/
`timescale 1ns/100ps

module xif_coproc (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // Issue channel
  input  logic                             x_issue_valid_i,
  output logic                             x_issue_ready_o,
  input  xif_offload_pkg::cp_issue_req_t   x_issue_req_i,
  output xif_offload_pkg::cp_issue_resp_t  x_issue_resp_o,
  // Commit channel
  input  logic                             x_commit_valid_i,
  input  xif_offload_pkg::cp_commit_t      x_commit_i,
  // Result channel
  output logic                             x_result_valid_o,
  input  logic                             x_result_ready_i,
  output xif_offload_pkg::cp_result_t      x_result_o
);

  import xif_offload_pkg::*;

  coproc_state_e state_q, state_d;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  logic       issue_hs;
  logic       commit_match;

  // Latched instruction
  xif_id_t    id_q;
  reg_addr_t  rd_q;
  cp_op_e     op_q;
  xlen_t      rs1_q;
  xlen_t      rs2_q;
  xlen_t      res_q;

  xlen_t        alu_res;
  logic [63:0]  rol_tmp;

  // R-type decode
  assign opcode = x_issue_req_i.instr[6:0];
  assign funct3 = x_issue_req_i.instr[14:12];
  assign funct7 = x_issue_req_i.instr[31:25];
  assign legal  = (opcode == OPCODE_CUSTOM0) && (funct7 == '0) && (funct3 <= 3'd4);

  assign x_issue_ready_o = (state_q == CP_IDLE);
  assign issue_hs        = x_issue_valid_i && x_issue_ready_o;

  assign x_issue_resp_o.accept    = legal;
  assign x_issue_resp_o.writeback = legal;
  assign x_issue_resp_o.dualwrite = 1'b0;
  assign x_issue_resp_o.dualread  = '0;
  assign x_issue_resp_o.loadstore = 1'b0;
  assign x_issue_resp_o.exc       = 1'b0;

  assign commit_match = x_commit_valid_i && (x_commit_i.id == id_q);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CP_IDLE: begin
        if (issue_hs && legal) begin
          state_d = CP_WAIT_COMMIT;
        end
      end
      CP_WAIT_COMMIT: begin
        if (commit_match) begin
          state_d = x_commit_i.commit_kill ? CP_IDLE : CP_RESULT;
        end
      end
      CP_RESULT: begin
        if (x_result_ready_i) begin
          state_d = CP_IDLE;
        end
      end
      default: state_d = CP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_hs && legal) begin
      id_q  <= x_issue_req_i.id;
      rd_q  <= x_issue_req_i.instr[11:7];
      op_q  <= cp_op_e'(funct3);
      rs1_q <= x_issue_req_i.rs[0];
      rs2_q <= x_issue_req_i.rs[1];
    end
    if (state_q == CP_WAIT_COMMIT && commit_match && !x_commit_i.commit_kill) begin
      res_q <= alu_res;
    end
  end

  // Rotate as the upper half of a doubled word shifted left
  assign rol_tmp = {rs1_q, rs1_q} << rs2_q[4:0];

  always_comb begin
    unique case (op_q)
      OP_ADD:  alu_res = rs1_q + rs2_q;
      OP_SUB:  alu_res = rs1_q - rs2_q;
      OP_XOR:  alu_res = rs1_q ^ rs2_q;
      OP_MINU: alu_res = (rs1_q < rs2_q) ? rs1_q : rs2_q;
      OP_ROL:  alu_res = rol_tmp[63:32];
      default: alu_res = '0;
    endcase
  end

  assign x_result_valid_o  = (state_q == CP_RESULT);
  assign x_result_o.id     = id_q;
  assign x_result_o.data   = res_q;
  assign x_result_o.rd     = rd_q;
  assign x_result_o.we     = 1'b1;
  assign x_result_o.hartid = 1'b0;

endmodule

// File: design/xif_offload_top.sv
/*
  Offload subsystem top: core-side issuer, interface adapter and
  custom-0 coprocessor in a chain
*/
`timescale 1ns/100ps

module xif_offload_top #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        offload_valid_i,
  input  xif_offload_pkg::instr_t     offload_instr_i,
  output logic                        offload_ready_o,
  input  logic                        reg_we_i,
  input  xif_offload_pkg::reg_addr_t  reg_waddr_i,
  input  xif_offload_pkg::xlen_t      reg_wdata_i,
  input  xif_offload_pkg::reg_addr_t  reg_raddr_i,
  output xif_offload_pkg::xlen_t      reg_rdata_o,
  output logic                        done_o,
  output logic                        illegal_o
);

  import xif_offload_pkg::*;

  // Core side, narrow
  logic             core_issue_valid;
  logic             core_issue_ready;
  core_issue_req_t  core_issue_req;
  core_register_t   core_register;
  core_issue_resp_t core_issue_resp;
  logic             core_commit_valid;
  core_commit_t     core_commit;
  logic             core_result_valid;
  logic             core_result_ready;
  core_result_t     core_result;

  // Coprocessor side, wide
  logic             cp_issue_valid;
  logic             cp_issue_ready;
  cp_issue_req_t    cp_issue_req;
  cp_issue_resp_t   cp_issue_resp;
  logic             cp_commit_valid;
  cp_commit_t       cp_commit;
  logic             cp_result_valid;
  logic             cp_result_ready;
  cp_result_t       cp_result;

  offload_issuer #(
    .NumRegs(NumRegs)
  ) u_issuer (
    .clk_i,
    .arst_n_i,
    .offload_valid_i,
    .offload_instr_i,
    .offload_ready_o,
    .reg_we_i,
    .reg_waddr_i,
    .reg_wdata_i,
    .reg_raddr_i,
    .reg_rdata_o,
    .done_o,
    .illegal_o,
    .x_issue_valid_o (core_issue_valid),
    .x_issue_ready_i (core_issue_ready),
    .x_issue_req_o   (core_issue_req),
    .x_register_o    (core_register),
    .x_issue_resp_i  (core_issue_resp),
    .x_commit_valid_o(core_commit_valid),
    .x_commit_o      (core_commit),
    .x_result_valid_i(core_result_valid),
    .x_result_ready_o(core_result_ready),
    .x_result_i      (core_result)
  );

  xif_adapter u_adapter (
    .clk_i,
    .arst_n_i,
    .x_issue_valid_i  (core_issue_valid),
    .x_issue_ready_o  (core_issue_ready),
    .x_issue_req_i    (core_issue_req),
    .x_register_i     (core_register),
    .x_issue_resp_o   (core_issue_resp),
    .x_commit_valid_i (core_commit_valid),
    .x_commit_i       (core_commit),
    .x_result_valid_o (core_result_valid),
    .x_result_ready_i (core_result_ready),
    .x_result_o       (core_result),
    .cp_issue_valid_o (cp_issue_valid),
    .cp_issue_ready_i (cp_issue_ready),
    .cp_issue_req_o   (cp_issue_req),
    .cp_issue_resp_i  (cp_issue_resp),
    .cp_commit_valid_o(cp_commit_valid),
    .cp_commit_o      (cp_commit),
    .cp_result_valid_i(cp_result_valid),
    .cp_result_ready_o(cp_result_ready),
    .cp_result_i      (cp_result)
  );

  xif_coproc u_coproc (
    .clk_i,
    .arst_n_i,
    .x_issue_valid_i (cp_issue_valid),
    .x_issue_ready_o (cp_issue_ready),
    .x_issue_req_i   (cp_issue_req),
    .x_issue_resp_o  (cp_issue_resp),
    .x_commit_valid_i(cp_commit_valid),
    .x_commit_i      (cp_commit),
    .x_result_valid_o(cp_result_valid),
    .x_result_ready_i(cp_result_ready),
    .x_result_o      (cp_result)
  );

endmodule

// File: test/tb_xif_offload.sv
/*
  Testbench for the offload subsystem. Drives seeded random custom-0
  traffic and checks results against a register-file model
*/
`timescale 1ns/100ps

module tb_xif_offload;

  import xif_offload_pkg::*;

  localparam int NUM_REGS     = 16;
  localparam int RESET_CYCLES = 5;
  localparam int N_ACCEPT     = 40;
  localparam int N_REJECT     = 12;
  localparam int N_RD_ZERO    = 8;
  localparam int N_STREAM     = 30;
  localparam int N_OPS        = N_ACCEPT + N_REJECT + N_RD_ZERO + N_STREAM;
  // Reset, preload and every register readback
  localparam int SETUP_CYCLES    = RESET_CYCLES + 6 * 32 + N_ACCEPT + N_RD_ZERO;
  localparam int WATCHDOG_CYCLES = N_OPS * 20 + SETUP_CYCLES;

  logic      clk;
  logic      arst_n;
  logic      offload_valid;
  instr_t    offload_instr;
  logic      offload_ready;
  logic      reg_we;
  reg_addr_t reg_waddr;
  xlen_t     reg_wdata;
  reg_addr_t reg_raddr;
  xlen_t     reg_rdata;
  logic      done;
  logic      illegal;

  // Expected register contents
  xlen_t model_rf [32];
  int    errors;
  int    checks;
  int    tests_run;
  int    errors_at_start;

  xif_offload_top #(
    .NumRegs(NUM_REGS)
  ) dut_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .offload_valid_i(offload_valid),
    .offload_instr_i(offload_instr),
    .offload_ready_o(offload_ready),
    .reg_we_i       (reg_we),
    .reg_waddr_i    (reg_waddr),
    .reg_wdata_i    (reg_wdata),
    .reg_raddr_i    (reg_raddr),
    .reg_rdata_o    (reg_rdata),
    .done_o         (done),
    .illegal_o      (illegal)
  );

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("Test %0d %-18s %0d errors", tests_run, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // Called on a falling edge and returns on the next one
  task automatic check_register(input int idx);
    reg_raddr = reg_addr_t'(idx);
    #5;
    check_value($sformatf("reg_rdata_o[%0d]", idx), model_rf[idx], reg_rdata);
    @(negedge clk);
  endtask

  task automatic readback_all();
    for (int i = 0; i < 32; i++) begin
      check_register(i);
    end
  endtask

  task automatic preload_regs();
    for (int i = 0; i < 32; i++) begin
      reg_we    = 1'b1;
      reg_waddr = reg_addr_t'(i);
      reg_wdata = $urandom();
      if (i != 0 && i < NUM_REGS) begin
        model_rf[i] = reg_wdata;
      end
      @(negedge clk);
    end
    reg_we = 1'b0;
  endtask

  function automatic instr_t build_instr(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [6:0] opcode);
    return {funct7, rs2, rs1, funct3, rd, opcode};
  endfunction

  function automatic bit is_legal(input instr_t instr);
    return (instr[6:0] == OPCODE_CUSTOM0) && (instr[31:25] == 7'd0) && (instr[14:12] < 3'd5);
  endfunction

  function automatic xlen_t model_result(input instr_t instr);
    xlen_t a;
    xlen_t b;
    int    sh;
    a  = model_rf[instr[19:15]];
    b  = model_rf[instr[24:20]];
    sh = int'(b & 32'd31);
    case (instr[14:12])
      3'd0:    return a + b;
      3'd1:    return a - b;
      3'd2:    return a ^ b;
      3'd3:    return (a < b) ? a : b;
      default: return (sh == 0) ? a : ((a << sh) | (a >> (32 - sh)));
    endcase
  endfunction

  function automatic instr_t random_legal(input bit rd_zero);
    logic [4:0] rd;
    rd = rd_zero ? 5'd0 : 5'($urandom_range(31, 0));
    return build_instr(7'd0, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                       3'($urandom_range(4, 0)), rd, OPCODE_CUSTOM0);
  endfunction

  // Wrong opcode, non-zero funct7 or an unused funct3
  function automatic instr_t random_illegal();
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    int         kind;
    kind   = $urandom_range(2, 0);
    opcode = OPCODE_CUSTOM0;
    funct7 = 7'd0;
    funct3 = 3'($urandom_range(4, 0));
    if (kind == 0) begin
      opcode = 7'($urandom_range(127, 0));
      if (opcode == OPCODE_CUSTOM0) begin
        opcode = opcode ^ 7'h40;
      end
    end else if (kind == 1) begin
      funct7 = 7'($urandom_range(127, 1));
    end else begin
      funct3 = 3'($urandom_range(7, 5));
    end
    return build_instr(funct7, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                       funct3, 5'($urandom_range(31, 0)), opcode);
  endfunction

  // Offer one instruction and count completion pulses until ready returns
  task automatic issue_and_wait(input instr_t instr, input instr_t next_instr, input bit hold,
                                output int n_done, output int n_illegal);
    n_done        = 0;
    n_illegal     = 0;
    offload_valid = 1'b1;
    offload_instr = instr;
    while (!offload_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    // Accepted on the rising edge just passed
    if (hold) begin
      offload_instr = next_instr;
    end else begin
      offload_valid = 1'b0;
    end
    while (!offload_ready) begin
      if (done) begin
        n_done++;
      end
      if (illegal) begin
        n_illegal++;
      end
      @(negedge clk);
    end
  endtask

  task automatic run_instr(input instr_t instr, input instr_t next_instr, input bit hold);
    int         n_done;
    int         n_illegal;
    bit         legal;
    logic [4:0] rd;
    legal = is_legal(instr);
    rd    = instr[11:7];
    issue_and_wait(instr, next_instr, hold, n_done, n_illegal);
    check_value("done_o pulses", legal ? 32'd1 : 32'd0, xlen_t'(n_done));
    check_value("illegal_o pulses", legal ? 32'd0 : 32'd1, xlen_t'(n_illegal));
    if (legal && rd != 5'd0 && rd < NUM_REGS) begin
      model_rf[rd] = model_result(instr);
    end
  endtask

  initial begin
    instr_t cur;
    instr_t nxt;
    void'($urandom(5561));
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    errors_at_start = 0;
    arst_n          = 1'b0;
    offload_valid   = 1'b0;
    offload_instr   = '0;
    reg_we          = 1'b0;
    reg_waddr       = '0;
    reg_wdata       = '0;
    reg_raddr       = '0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // Idle outputs and an all-zero register file out of reset
    check_value("offload_ready_o", 32'd1, xlen_t'(offload_ready));
    check_value("done_o", 32'd0, xlen_t'(done));
    check_value("illegal_o", 32'd0, xlen_t'(illegal));
    readback_all();
    report_test("reset_values");

    preload_regs();
    readback_all();
    report_test("preload_readback");

    for (int i = 0; i < N_ACCEPT; i++) begin
      cur = random_legal(1'b0);
      run_instr(cur, cur, 1'b0);
      check_register(int'(cur[11:7]));
    end
    report_test("accepted_ops");

    for (int i = 0; i < N_REJECT; i++) begin
      cur = random_illegal();
      run_instr(cur, cur, 1'b0);
    end
    readback_all();
    report_test("rejections");

    for (int i = 0; i < N_RD_ZERO; i++) begin
      cur = random_legal(1'b1);
      run_instr(cur, cur, 1'b0);
      check_register(0);
    end
    report_test("rd_zero");

    // Valid stays high and the next instruction follows each acceptance
    nxt = random_legal(1'b0);
    for (int i = 0; i < N_STREAM; i++) begin
      cur = nxt;
      nxt = ($urandom_range(3, 0) == 0) ? random_illegal() : random_legal(1'b0);
      run_instr(cur, nxt, i != N_STREAM - 1);
    end
    readback_all();
    report_test("back_to_back");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: xif_offload.f
design/xif_offload_pkg.sv
design/offload_issuer.sv
design/xif_adapter.sv
design/xif_coproc.sv
design/xif_offload_top.sv
test/tb_xif_offload.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the offload testbench with Verilator, run it and scan the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f xif_offload.f --top-module tb_xif_offload \
  -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb | tee "$LOG" \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "TESTS FAILED" "$LOG" \
  && { echo "Simulation reported failures, see $LOG"; exit 1; } \
  || { echo "Simulation clean"; exit 0; }
